// ==== design/bf16_settings.svh ====
`ifndef BF16_SETTINGS_SVH
`define BF16_SETTINGS_SVH

`default_nettype none

// Field widths of the bfloat16 format
`define BF16_EXP_WIDTH 8
`define BF16_MAN_WIDTH 7

// Exponent value that marks an infinity
`define BF16_EXP_MAX 255

// Clocks from operands to result
`define ADD_LATENCY 3

`default_nettype wire

`endif

// ==== design/bf16Pkg.sv ====
`include "bf16_settings.svh"

`default_nettype none

package bf16Pkg;

    // ------------------------------------------------------------------------
    // Field types of the number format
    // ------------------------------------------------------------------------
    typedef logic [`BF16_EXP_WIDTH-1:0] bf16Exp;
    typedef logic [`BF16_MAN_WIDTH-1:0] bf16Man;

    // Significand with the hidden one in front
    typedef logic [`BF16_MAN_WIDTH:0] bf16Sig;

    typedef struct packed {
        logic   sign;
        bf16Exp exponent;
        bf16Man mantissa;
    } bf16Fields;

    // One word, read either as raw bits or as its fields
    typedef union packed {
        logic [`BF16_EXP_WIDTH+`BF16_MAN_WIDTH:0] bits;
        bf16Fields                                fields;
    } bf16Word;

    // ------------------------------------------------------------------------
    // Status of one addition
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic overflow;
        logic underflow;
        logic inexact;
    } addFlags;

endpackage

`default_nettype wire

// ==== design/addPipePkg.sv ====
`include "bf16_settings.svh"

`default_nettype none

package addPipePkg;

    // Significand result with room for the carry
    typedef logic [`BF16_MAN_WIDTH+1:0] sumSig;

    // ------------------------------------------------------------------------
    // Align to combine
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic            sign;
        logic            subtract;
        bf16Pkg::bf16Exp exponent;
        bf16Pkg::bf16Sig bigSig;
        bf16Pkg::bf16Sig smallSig;
        logic            sticky;
        // Equal magnitudes under subtraction
        logic            zeroResult;
    } alignedOps;

    // ------------------------------------------------------------------------
    // Combine to normalize
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic            sign;
        bf16Pkg::bf16Exp exponent;
        sumSig           significand;
        logic            sticky;
        logic            zeroResult;
    } rawSum;

endpackage

`default_nettype wire

// ==== design/bf16Align.sv ====
`timescale 1ns/1ps

`include "bf16_settings.svh"

`default_nettype none

module bf16Align (
    input  logic                  clk,
    input  logic                  reset,
    input  bf16Pkg::bf16Word      opA,
    input  bf16Pkg::bf16Word      opB,
    output addPipePkg::alignedOps aligned
);

    import bf16Pkg::*;
    import addPipePkg::*;

    bf16Fields  fieldsA;
    bf16Fields  fieldsB;
    bf16Sig     sigA;
    bf16Sig     sigB;
    logic       aLarger;
    logic       sameMagnitude;
    bf16Exp     bigExp;
    bf16Exp     smallExp;
    bf16Exp     expDiff;
    bf16Sig     bigSig;
    bf16Sig     smallSig;
    logic [3:0] shiftAmount;
    logic [2*(`BF16_MAN_WIDTH+1)-1:0] shiftWindow;
    alignedOps  alignNext;

    assign fieldsA = opA.fields;
    assign fieldsB = opB.fields;

    // ------------------------------------------------------------------------
    // Unpack, flushing exponent 0 to zero
    // ------------------------------------------------------------------------
    assign sigA = (fieldsA.exponent == '0) ? '0 : {1'b1, fieldsA.mantissa};
    assign sigB = (fieldsB.exponent == '0) ? '0 : {1'b1, fieldsB.mantissa};

    // Exponent first, then significand decides the order
    assign aLarger       = {fieldsA.exponent, sigA} >= {fieldsB.exponent, sigB};
    assign sameMagnitude = {fieldsA.exponent, sigA} == {fieldsB.exponent, sigB};

    assign bigExp   = aLarger ? fieldsA.exponent : fieldsB.exponent;
    assign smallExp = aLarger ? fieldsB.exponent : fieldsA.exponent;
    assign bigSig   = aLarger ? sigA : sigB;
    assign smallSig = aLarger ? sigB : sigA;

    assign expDiff = bigExp - smallExp;

    // ------------------------------------------------------------------------
    // Alignment shift
    // ------------------------------------------------------------------------
    // Shifts of a full significand or more leave nothing behind
    assign shiftAmount = (expDiff > bf16Exp'(`BF16_MAN_WIDTH + 1))
                       ? 4'(`BF16_MAN_WIDTH + 1) : expDiff[3:0];

    // Upper half keeps the aligned value, lower half catches lost bits
    assign shiftWindow = {smallSig, bf16Sig'(0)} >> shiftAmount;

    always_comb begin
        alignNext.sign       = aLarger ? fieldsA.sign : fieldsB.sign;
        alignNext.subtract   = fieldsA.sign ^ fieldsB.sign;
        alignNext.exponent   = bigExp;
        alignNext.bigSig     = bigSig;
        alignNext.smallSig   = shiftWindow[2*(`BF16_MAN_WIDTH+1)-1:`BF16_MAN_WIDTH+1];
        alignNext.sticky     = |shiftWindow[`BF16_MAN_WIDTH:0];
        alignNext.zeroResult = sameMagnitude && alignNext.subtract;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aligned <= '0;
        end else begin
            aligned <= alignNext;
        end
    end

endmodule

`default_nettype wire

// ==== design/bf16Combine.sv ====
`timescale 1ns/1ps

`default_nettype none

module bf16Combine (
    input  logic                  clk,
    input  logic                  reset,
    input  addPipePkg::alignedOps aligned,
    output addPipePkg::rawSum     raw
);

    import addPipePkg::*;

    sumSig sigResult;

    // ------------------------------------------------------------------------
    // Significand add or subtract
    // ------------------------------------------------------------------------
    // The larger operand is on the left, so the difference never goes negative
    always_comb begin
        if (aligned.subtract) begin
            sigResult = {1'b0, aligned.bigSig} - {1'b0, aligned.smallSig};
        end else begin
            sigResult = {1'b0, aligned.bigSig} + {1'b0, aligned.smallSig};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            raw <= '0;
        end else begin
            raw.sign        <= aligned.sign;
            raw.exponent    <= aligned.exponent;
            raw.significand <= sigResult;
            raw.sticky      <= aligned.sticky;
            raw.zeroResult  <= aligned.zeroResult;
        end
    end

endmodule

`default_nettype wire

// ==== design/bf16Normalize.sv ====
`timescale 1ns/1ps

`include "bf16_settings.svh"

`default_nettype none

module bf16Normalize (
    input  logic              clk,
    input  logic              reset,
    input  addPipePkg::rawSum raw,
    output bf16Pkg::bf16Word  sum,
    output bf16Pkg::addFlags  flags
);

    import bf16Pkg::*;

    logic                     carry;
    logic [2:0]               leadCount;
    bf16Exp                   leadShift;
    bf16Sig                   normSig;
    logic [`BF16_EXP_WIDTH:0] normExp;
    logic                     isZero;
    logic                     underflowNext;
    logic                     overflowNext;
    logic                     inexactNext;
    bf16Word                  sumNext;
    addFlags                  flagsNext;

    // Position of the leading one, counted from the top
    function automatic logic [2:0] leadZeros(input bf16Sig value);
        logic [2:0] count;
        count = 3'd0;
        for (int i = 0; i <= `BF16_MAN_WIDTH; i++) begin
            if (value[i]) begin
                count = 3'(`BF16_MAN_WIDTH - i);
            end
        end
        return count;
    endfunction

    assign carry     = raw.significand[`BF16_MAN_WIDTH+1];
    assign leadCount = leadZeros(raw.significand[`BF16_MAN_WIDTH:0]);
    assign leadShift = {{(`BF16_EXP_WIDTH-3){1'b0}}, leadCount};
    assign isZero    = raw.zeroResult || (raw.significand == '0);

    // ------------------------------------------------------------------------
    // Renormalize
    // ------------------------------------------------------------------------
    always_comb begin
        if (carry) begin
            normSig     = raw.significand[`BF16_MAN_WIDTH+1:1];
            normExp     = {1'b0, raw.exponent} + {{`BF16_EXP_WIDTH{1'b0}}, 1'b1};
            inexactNext = raw.sticky | raw.significand[0];
        end else begin
            normSig     = raw.significand[`BF16_MAN_WIDTH:0] << leadCount;
            normExp     = {1'b0, raw.exponent - leadShift};
            inexactNext = raw.sticky;
        end
    end

    // Exponent would drop to 0 or below
    assign underflowNext = !isZero && !carry && (raw.exponent <= leadShift);

    assign overflowNext = !isZero && !underflowNext
                        && (normExp >= {1'b0, bf16Exp'(`BF16_EXP_MAX)});

    // ------------------------------------------------------------------------
    // Special cases and packing
    // ------------------------------------------------------------------------
    always_comb begin
        sumNext.fields.sign     = raw.sign;
        sumNext.fields.exponent = normExp[`BF16_EXP_WIDTH-1:0];
        sumNext.fields.mantissa = normSig[`BF16_MAN_WIDTH-1:0];

        if (isZero) begin
            // Cancellation always gives +0
            sumNext.fields.sign     = raw.sign & ~raw.zeroResult;
            sumNext.fields.exponent = '0;
            sumNext.fields.mantissa = '0;
        end else if (underflowNext) begin
            sumNext.fields.exponent = '0;
            sumNext.fields.mantissa = '0;
        end else if (overflowNext) begin
            // Signed infinity
            sumNext.fields.exponent = bf16Exp'(`BF16_EXP_MAX);
            sumNext.fields.mantissa = '0;
        end
    end

    always_comb begin
        flagsNext.overflow  = overflowNext;
        flagsNext.underflow = underflowNext;
        flagsNext.inexact   = inexactNext;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum   <= '0;
            flags <= '0;
        end else begin
            sum   <= sumNext;
            flags <= flagsNext;
        end
    end

endmodule

`default_nettype wire

// ==== design/bf16Adder.sv ====
`timescale 1ns/1ps

`default_nettype none

module bf16Adder (
    input  logic             clk,
    input  logic             reset,
    input  bf16Pkg::bf16Word opA,
    input  bf16Pkg::bf16Word opB,
    output bf16Pkg::bf16Word sum,
    output bf16Pkg::addFlags flags
);

    import addPipePkg::*;

    // Stage registers between the three pipeline steps
    alignedOps alignedStage;
    rawSum     rawStage;

    // ------------------------------------------------------------------------
    // Stage 1, align
    // ------------------------------------------------------------------------
    bf16Align bf16Align_i (
        .clk     (clk),
        .reset   (reset),
        .opA     (opA),
        .opB     (opB),
        .aligned (alignedStage)
    );

    // ------------------------------------------------------------------------
    // Stage 2, combine
    // ------------------------------------------------------------------------
    bf16Combine bf16Combine_i (
        .clk     (clk),
        .reset   (reset),
        .aligned (alignedStage),
        .raw     (rawStage)
    );

    // ------------------------------------------------------------------------
    // Stage 3, normalize and flag
    // ------------------------------------------------------------------------
    bf16Normalize bf16Normalize_i (
        .clk   (clk),
        .reset (reset),
        .raw   (rawStage),
        .sum   (sum),
        .flags (flags)
    );

endmodule

`default_nettype wire

// ==== verification/bf16Adder_chk.sv ====
`timescale 1ns/1ps

`include "bf16_settings.svh"

`default_nettype none

module bf16Adder_chk (
    input logic             clk,
    input logic             reset,
    input bf16Pkg::bf16Word sum,
    input bf16Pkg::addFlags flags
);

    import bf16Pkg::*;

    // Clocks left before the first operands can reach the outputs
    int   settleCount = 0;
    logic quietFailed = 1'b0;
    logic overflowFailed = 1'b0;
    logic underflowFailed = 1'b0;
    logic exclusiveFailed = 1'b0;
    logic anyFailed;

    assign anyFailed = quietFailed | overflowFailed | underflowFailed | exclusiveFailed;

    always_ff @(posedge clk) begin
        if (reset) begin
            settleCount <= `ADD_LATENCY;
        end else if (settleCount != 0) begin
            settleCount <= settleCount - 1;
        end
    end

    // ------------------------------------------------------------------------
    // Output flag properties
    // ------------------------------------------------------------------------
    flagsQuiet: assert property (@(posedge clk) (settleCount != 0) |-> (flags == '0))
        else begin
            quietFailed = 1'b1;
            $error("flags set during reset or before the pipeline filled");
        end

    overflowIsInfinity: assert property (@(posedge clk) disable iff (reset)
        flags.overflow |-> (sum.fields.exponent == bf16Exp'(`BF16_EXP_MAX)
                            && sum.fields.mantissa == '0))
        else begin
            overflowFailed = 1'b1;
            $error("overflow without an infinity on the sum");
        end

    underflowIsZero: assert property (@(posedge clk) disable iff (reset)
        flags.underflow |-> (sum.fields.exponent == '0 && sum.fields.mantissa == '0))
        else begin
            underflowFailed = 1'b1;
            $error("underflow with a nonzero sum");
        end

    flagsExclusive: assert property (@(posedge clk) disable iff (reset)
        !(flags.overflow && flags.underflow))
        else begin
            exclusiveFailed = 1'b1;
            $error("overflow and underflow set together");
        end

endmodule

bind bf16Adder bf16Adder_chk bf16Adder_chk_i (
    .clk   (clk),
    .reset (reset),
    .sum   (sum),
    .flags (flags)
);

`default_nettype wire

// ==== verification/bf16AdderTb.sv ====
`timescale 1ns/1ps

`include "bf16_settings.svh"

`default_nettype none

module bf16AdderTb;

    import bf16Pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    localparam int HIDDEN_ONE   = 1 << `BF16_MAN_WIDTH;
    localparam int NUM_LISTED   = 18;
    localparam int NUM_SHIFTS   = 10;
    localparam int NUM_RANDOM   = 2000;
    localparam int TOTAL_OPS    = NUM_LISTED + 2 * NUM_SHIFTS + NUM_RANDOM;
    // First negedge at which a real result sits on the outputs
    localparam int FIRST_DUE    = RESET_CYCLES + `ADD_LATENCY;
    localparam int WATCHDOG_NS  = (FIRST_DUE + TOTAL_OPS + 50) * CLK_PERIOD;

    localparam logic [31:0] LFSR_SEED = 32'hb316914e;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // Operand pairs, opA in the upper half
    localparam logic [31:0] DIRECTED_PAIRS [NUM_LISTED] = '{
        32'h3F80_3F00, 32'h3F80_3F80, 32'h3FC0_3FC0, 32'h3F81_3F80,  // same sign
        32'h3F80_BF40, 32'hBFC0_3F80, 32'h4049_C049, 32'hC049_4049,  // opposite sign
        32'h4300_C2FE,                                               // deep cancellation
        32'h7F7F_7F7F, 32'hFF7F_FF00, 32'h7F80_3F80,                 // overflow
        32'h0100_80FF, 32'h8180_0170,                                // underflow
        32'h007F_3F80, 32'h0000_8000, 32'h8000_8000, 32'h8005_0003   // exponent 0
    };

    typedef struct packed {
        int      due;
        bf16Word opA;
        bf16Word opB;
        bf16Word sum;
        addFlags flags;
    } expectedResult;

    logic          clk = 1'b0;
    logic          reset;
    bf16Word       opA;
    bf16Word       opB;
    bf16Word       sum;
    addFlags       flags;
    int            cycleCount = 0;
    int            checkedCount = 0;
    logic [31:0]   lfsrState = LFSR_SEED;
    expectedResult expectQ[$];

    bf16Adder bf16Adder_i (
        .clk   (clk),
        .reset (reset),
        .opA   (opA),
        .opB   (opB),
        .sum   (sum),
        .flags (flags)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // ------------------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic bf16Word makeWord(input logic sign, input bf16Exp exponent,
                                         input bf16Man mantissa);
        bf16Word word;
        word.fields.sign     = sign;
        word.fields.exponent = exponent;
        word.fields.mantissa = mantissa;
        return word;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model, round toward zero with flush to zero
    // ------------------------------------------------------------------------
    function automatic void refAdd(input bf16Word a, input bf16Word b,
                                   output bf16Word s, output addFlags f);
        int   expA, expB, sigA, sigB;
        int   bigExp, smallExp, bigSig, smallSig;
        int   shift, kept, result, newExp;
        logic bigSign, subtract, inexact;
        expA = int'(a.fields.exponent);
        expB = int'(b.fields.exponent);
        sigA = (expA == 0) ? 0 : HIDDEN_ONE + int'(a.fields.mantissa);
        sigB = (expB == 0) ? 0 : HIDDEN_ONE + int'(b.fields.mantissa);
        if (expA * 256 + sigA >= expB * 256 + sigB) begin
            bigExp   = expA;
            bigSig   = sigA;
            smallExp = expB;
            smallSig = sigB;
            bigSign  = a.fields.sign;
        end else begin
            bigExp   = expB;
            bigSig   = sigB;
            smallExp = expA;
            smallSig = sigA;
            bigSign  = b.fields.sign;
        end
        subtract = a.fields.sign != b.fields.sign;
        shift = bigExp - smallExp;
        if (shift > `BF16_MAN_WIDTH + 1) shift = `BF16_MAN_WIDTH + 1;
        kept    = smallSig >> shift;
        inexact = (smallSig - (kept << shift)) != 0;
        result  = subtract ? bigSig - kept : bigSig + kept;
        newExp  = bigExp;
        f.overflow  = 1'b0;
        f.underflow = 1'b0;
        s = '0;
        if (result == 0) begin
            s.fields.sign = subtract ? 1'b0 : bigSign;
        end else begin
            if (result >= 2 * HIDDEN_ONE) begin
                inexact = inexact || ((result & 1) != 0);
                result  = result >> 1;
                newExp  = bigExp + 1;
            end
            while (result < HIDDEN_ONE) begin
                result = result << 1;
                newExp = newExp - 1;
            end
            s.fields.sign = bigSign;
            if (newExp <= 0) begin
                f.underflow = 1'b1;
            end else if (newExp >= `BF16_EXP_MAX) begin
                f.overflow = 1'b1;
                s.fields.exponent = bf16Exp'(`BF16_EXP_MAX);
            end else begin
                s.fields.exponent = bf16Exp'(newExp);
                s.fields.mantissa = bf16Man'(result - HIDDEN_ONE);
            end
        end
        f.inexact = inexact;
    endfunction

    // ------------------------------------------------------------------------
    // Failure handling and compare tasks
    // ------------------------------------------------------------------------
    task automatic abortRun(input string reason);
        $display("** FAIL **");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input bf16Word got, input bf16Word expected, input string what);
        if (got.bits !== expected.bits) begin
            $display("[FAIL] %0d ns: %s gave sum %h, expected %h",
                     $time, what, got.bits, expected.bits);
            abortRun("sum mismatch");
        end
    endtask

    task automatic checkFlags(input addFlags got, input addFlags expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0d ns: %s gave flags %b, expected %b (ovf unf inx)",
                     $time, what, got, expected);
            abortRun("flag mismatch");
        end
    endtask

    // Outputs are compared half a clock after they change
    always @(negedge clk) begin
        expectedResult head;
        if (bf16Adder_i.bf16Adder_chk_i.anyFailed) begin
            abortRun("an assertion in bf16Adder_chk failed");
        end else if (cycleCount < FIRST_DUE) begin
            checkWord(sum, bf16Word'(16'h0000), "pipeline during reset and fill");
            checkFlags(flags, addFlags'(3'b000), "pipeline during reset and fill");
        end else if (expectQ.size() > 0) begin
            head = expectQ.pop_front();
            if (head.due != cycleCount) begin
                abortRun("a result left the pipeline out of step with its operands");
            end else begin
                checkWord(sum, head.sum, $sformatf("%h + %h", head.opA.bits, head.opB.bits));
                checkFlags(flags, head.flags,
                           $sformatf("%h + %h", head.opA.bits, head.opB.bits));
                checkedCount = checkedCount + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    // Drives at the current falling edge and moves on to the next one
    task automatic issue(input bf16Word a, input bf16Word b);
        expectedResult entry;
        bf16Word       expectedSum;
        addFlags       expectedFlags;
        opA = a;
        opB = b;
        refAdd(a, b, expectedSum, expectedFlags);
        entry.due   = cycleCount + `ADD_LATENCY;
        entry.opA   = a;
        entry.opB   = b;
        entry.sum   = expectedSum;
        entry.flags = expectedFlags;
        expectQ.push_back(entry);
        @(negedge clk);
    endtask

    task automatic issueRandom();
        bf16Exp  expA;
        bf16Exp  expB;
        bf16Exp  offset;
        bf16Word a;
        bf16Word b;
        case (2'(randomBits(2)))
            2'd0:    expA = bf16Exp'(randomBits(4));
            2'd1:    expA = bf16Exp'(`BF16_EXP_MAX) - bf16Exp'(randomBits(4));
            default: expA = bf16Exp'(randomBits(8));
        endcase
        // Mostly close exponents, now and then any exponent
        offset = bf16Exp'(randomBits(4));
        if (1'(randomBits(1))) begin
            expB = expA + offset;
        end else begin
            expB = expA - offset;
        end
        if (2'(randomBits(2)) == 2'd0) begin
            expB = bf16Exp'(randomBits(8));
        end
        a = makeWord(1'(randomBits(1)), expA, bf16Man'(randomBits(7)));
        b = makeWord(1'(randomBits(1)), expB, bf16Man'(randomBits(7)));
        if (3'(randomBits(3)) == 3'd0) begin
            b = a;
            b.fields.sign = ~a.fields.sign;
        end
        issue(a, b);
    endtask

    initial begin
        bf16Word a;
        bf16Word b;
        reset = 1'b1;
        // Operands are live during reset and must not reach the outputs
        opA.bits = 16'h4049;
        opB.bits = 16'h3F80;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NUM_LISTED; i++) begin
            a.bits = DIRECTED_PAIRS[i][31:16];
            b.bits = DIRECTED_PAIRS[i][15:0];
            issue(a, b);
        end

        // Exponent gaps from 1 to beyond the significand width
        for (int d = 1; d <= NUM_SHIFTS; d++) begin
            issue(makeWord(1'b0, 8'd127, 7'h00), makeWord(1'b0, bf16Exp'(127 - d), 7'h7F));
            issue(makeWord(1'b0, 8'd128, 7'h00), makeWord(1'b1, bf16Exp'(128 - d), 7'h00));
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            issueRandom();
        end

        wait (checkedCount == TOTAL_OPS);
        $display("** PASS **");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d of %0d results checked",
                 WATCHDOG_NS, checkedCount, TOTAL_OPS);
        abortRun("the run did not finish in time");
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/bf16Pkg.sv
design/addPipePkg.sv
design/bf16Align.sv
design/bf16Combine.sv
design/bf16Normalize.sv
design/bf16Adder.sv
verification/bf16Adder_chk.sv
verification/bf16AdderTb.sv

// ==== Makefile ====
# Verilator build and run of the bfloat16 adder testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module bf16AdderTb -f files.f
	./obj_dir/Vbf16AdderTb +verilator+error+limit+1000

clean:
	rm -rf obj_dir
